//--- logic/addr_demux.sv
// address decode and request routing to rom, sram and exit register
// response select and error response for unmapped addresses

`timescale 1ns/1ps

module addr_demux (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             req_i,
  input  logic             we_i,
  input  bus_pkg::addr_t   addr_i,
  input  bus_pkg::strb_t   be_i,
  input  bus_pkg::data_t   wdata_i,
  output logic             rvalid_o,
  output logic             err_o,
  output bus_pkg::data_t   rdata_o,
  mem_bus_if.master        rom_bus,
  mem_bus_if.master        sram_bus,
  mem_bus_if.master        exit_bus
);

  import bus_pkg::*;
  import soc_pkg::*;

  target_e    tgt_d;
  target_e    tgt_q;
  logic       req_q;
  logic [2:0] req_vec;
  logic [2:0] rsp_vec;

  // --------------------
  // request side
  // --------------------

  assign tgt_d = decode_target(addr_i);

  assign rom_bus.req  = req_i && (tgt_d == TgtRom);
  assign sram_bus.req = req_i && (tgt_d == TgtSram);
  assign exit_bus.req = req_i && (tgt_d == TgtExit);

  // targets see the aligned offset into their own window
  assign rom_bus.addr  = (addr_i - RomBase) & WordMask;
  assign sram_bus.addr = (addr_i - SramBase) & WordMask;
  assign exit_bus.addr = (addr_i - ExitBase) & WordMask;

  assign rom_bus.we     = we_i;
  assign rom_bus.be     = be_i;
  assign rom_bus.wdata  = wdata_i;
  assign sram_bus.we    = we_i;
  assign sram_bus.be    = be_i;
  assign sram_bus.wdata = wdata_i;
  assign exit_bus.we    = we_i;
  assign exit_bus.be    = be_i;
  assign exit_bus.wdata = wdata_i;

  // --------------------
  // response side
  // --------------------

  // target of the request one cycle back
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      tgt_q <= TgtNone;
      req_q <= 1'b0;
    end else begin
      tgt_q <= tgt_d;
      req_q <= req_i;
    end
  end

  always_comb begin
    rvalid_o = 1'b0;
    err_o    = 1'b0;
    rdata_o  = '0;
    case (tgt_q)
      TgtRom: begin
        rvalid_o = rom_bus.rvalid;
        err_o    = rom_bus.err;
        rdata_o  = rom_bus.rdata;
      end
      TgtSram: begin
        rvalid_o = sram_bus.rvalid;
        err_o    = sram_bus.err;
        rdata_o  = sram_bus.rdata;
      end
      TgtExit: begin
        rvalid_o = exit_bus.rvalid;
        err_o    = exit_bus.err;
        rdata_o  = exit_bus.rdata;
      end
      default: begin
        // unmapped, answered here with zero data
        rvalid_o = req_q;
        err_o    = req_q;
      end
    endcase
  end

  assign req_vec = {rom_bus.req, sram_bus.req, exit_bus.req};
  assign rsp_vec = {rom_bus.rvalid, sram_bus.rvalid, exit_bus.rvalid};

  assert property (@(posedge clk_i) disable iff (!rst_ni) $onehot0(req_vec))
    else $error("more than one target selected");

  // a target only answers what it was asked the cycle before
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (rsp_vec & ~$past(req_vec)) == 3'b000)
    else $error("target response without a preceding request");

endmodule

//--- logic/boot_rom.sv
// boot rom with a fixed table built from the rom tag
// registered read and an error response on writes

`timescale 1ns/1ps

module boot_rom (
  input  logic      clk_i,
  mem_bus_if.slave  bus
);

  import bus_pkg::*;
  import soc_pkg::*;

  data_t                  rom_table [RomWords];
  logic [RomIdxWidth-1:0] idx;

  // index in the upper half of word i, index xor tag in the lower half
  for (genvar i = 0; i < RomWords; i++) begin : gen_table
    assign rom_table[i] = {32'(i), 32'(i) ^ RomTag};
  end

  assign idx = bus.addr[WordOffset +: RomIdxWidth];

  // response follows the request by one cycle
  always_ff @(posedge clk_i) begin
    bus.rvalid <= bus.req;
    bus.err    <= bus.req && bus.we;
    if (bus.req && !bus.we) begin
      bus.rdata <= rom_table[idx];
    end else begin
      bus.rdata <= '0;
    end
  end

endmodule

//--- logic/bus_pkg.sv
// memory bus widths and the word types built on them
// plus derived constants for word alignment

package bus_pkg;

  // --------------------
  // bus geometry
  // --------------------

  // byte address, one 64-bit word per transfer
  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 64;

  // one enable per byte lane
  localparam int unsigned StrbWidth = DataWidth / 8;

  // low address bits that pick a byte inside a word
  localparam int unsigned WordOffset = $clog2(StrbWidth);

  // --------------------
  // word types
  // --------------------

  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [DataWidth-1:0] data_t;
  typedef logic [StrbWidth-1:0] strb_t;

  // clears the byte select bits of an address
  localparam addr_t WordMask = ~addr_t'(StrbWidth - 1);

  // bits in one byte lane
  localparam int unsigned ByteWidth = DataWidth / StrbWidth;

endpackage

//--- logic/debug_req_gate.sv
// debug request gate
// post-reset hold-off counter and enable

`timescale 1ns/1ps

module debug_req_gate (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic dbg_req_i,
  input  logic dbg_enable_i,
  output logic debug_req_o
);

  import soc_pkg::*;

  logic [DebugCntWidth-1:0] cnt_q;
  logic                     hold;

  // gives the boot code time to run before the first debug request
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= DebugCntWidth'(DebugDelayCycles);
    end else if (cnt_q != '0) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  assign hold = (cnt_q != '0);

  // pass through only once the counter has run out
  assign debug_req_o = !hold && dbg_enable_i && dbg_req_i;

  assert property (@(posedge clk_i) disable iff (!rst_ni) hold |-> !debug_req_o)
    else $error("debug request passed during the hold-off window");

endmodule

//--- logic/exit_reg.sv
// end-of-test code register
// drives the exit output, reads back zero-extended

`timescale 1ns/1ps

module exit_reg (
  input  logic        clk_i,
  input  logic        rst_ni,
  mem_bus_if.slave    bus,
  output logic [31:0] exit_o
);

  import bus_pkg::*;

  logic [31:0] code_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      code_q     <= '0;
      bus.rvalid <= 1'b0;
    end else begin
      bus.rvalid <= bus.req;
      if (bus.req && bus.we) begin
        code_q <= bus.wdata[31:0];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (bus.req && !bus.we) begin
      bus.rdata <= data_t'(code_q);
    end else begin
      bus.rdata <= '0;
    end
  end

  assign bus.err = 1'b0;
  assign exit_o  = code_q;

endmodule

//--- logic/mem_bus_if.sv
// single-cycle request/response memory bus
// master and slave views

`timescale 1ns/1ps

interface mem_bus_if;

  import bus_pkg::*;

  // request, one cycle wide, never stalled
  logic  req;
  logic  we;
  addr_t addr;
  strb_t be;
  data_t wdata;

  // response, exactly one cycle after the request
  logic  rvalid;
  data_t rdata;
  logic  err;

  modport master (
    output req,
    output we,
    output addr,
    output be,
    output wdata,
    input  rvalid,
    input  rdata,
    input  err
  );

  modport slave (
    input  req,
    input  we,
    input  addr,
    input  be,
    input  wdata,
    output rvalid,
    output rdata,
    output err
  );

endinterface

//--- logic/reset_sync.sv
// platform reset: power-on reset merged with the non-debug reset
// request, asserted at once and released in step with the clock

`timescale 1ns/1ps

module reset_sync (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic ndmreset_i,
  output logic rst_no
);

  logic       rst_comb_n;
  logic [1:0] sync_q;

  // either source pulls the platform into reset
  assign rst_comb_n = rst_ni & ~ndmreset_i;

  // two stages, release lands on the second edge
  always_ff @(posedge clk_i or negedge rst_comb_n) begin
    if (!rst_comb_n) begin
      sync_q <= 2'b00;
    end else begin
      sync_q <= {sync_q[0], 1'b1};
    end
  end

  assign rst_no = sync_q[1];

  // a non-debug reset request always holds the platform in reset
  assert property (@(posedge clk_i) ndmreset_i |-> !rst_no)
    else $error("platform reset released while ndmreset is requested");

endmodule

//--- logic/soc_harness_top.sv
// platform top: reset sync, debug gate, address demux
// and the three bus targets

`timescale 1ns/1ps

module soc_harness_top (
  input  logic           clk_i,
  input  logic           rst_ni,
  input  logic           ndmreset_i,
  input  logic           dbg_req_i,
  input  logic           dbg_enable_i,
  input  logic           req_i,
  input  logic           we_i,
  input  bus_pkg::addr_t addr_i,
  input  bus_pkg::strb_t be_i,
  input  bus_pkg::data_t wdata_i,
  output logic           rvalid_o,
  output logic           err_o,
  output logic           debug_req_o,
  output bus_pkg::data_t rdata_o,
  output logic [31:0]    exit_o
);

  logic plat_rst_n;

  mem_bus_if rom_bus ();
  mem_bus_if sram_bus ();
  mem_bus_if exit_bus ();

  // --------------------
  // reset and debug
  // --------------------

  reset_sync i_reset_sync (
    .clk_i      ( clk_i      ),
    .rst_ni     ( rst_ni     ),
    .ndmreset_i ( ndmreset_i ),
    .rst_no     ( plat_rst_n )
  );

  // power-on reset only
  debug_req_gate i_debug_req_gate (
    .clk_i        ( clk_i        ),
    .rst_ni       ( rst_ni       ),
    .dbg_req_i    ( dbg_req_i    ),
    .dbg_enable_i ( dbg_enable_i ),
    .debug_req_o  ( debug_req_o  )
  );

  // --------------------
  // bus fabric
  // --------------------

  addr_demux i_addr_demux (
    .clk_i    ( clk_i      ),
    .rst_ni   ( plat_rst_n ),
    .req_i    ( req_i      ),
    .we_i     ( we_i       ),
    .addr_i   ( addr_i     ),
    .be_i     ( be_i       ),
    .wdata_i  ( wdata_i    ),
    .rvalid_o ( rvalid_o   ),
    .err_o    ( err_o      ),
    .rdata_o  ( rdata_o    ),
    .rom_bus  ( rom_bus    ),
    .sram_bus ( sram_bus   ),
    .exit_bus ( exit_bus   )
  );

  boot_rom i_boot_rom (
    .clk_i ( clk_i   ),
    .bus   ( rom_bus )
  );

  sram_bank i_sram_bank (
    .clk_i  ( clk_i      ),
    .rst_ni ( plat_rst_n ),
    .bus    ( sram_bus   )
  );

  exit_reg i_exit_reg (
    .clk_i  ( clk_i      ),
    .rst_ni ( plat_rst_n ),
    .bus    ( exit_bus   ),
    .exit_o ( exit_o     )
  );

endmodule

//--- logic/soc_pkg.sv
// platform address map, target select and memory sizes
// boot table tag and debug hold-off length

package soc_pkg;

  import bus_pkg::*;

  // --------------------
  // address map
  // --------------------

  localparam addr_t ExitBase = 32'h0000_1000;
  localparam addr_t RomBase  = 32'h0001_0000;
  localparam addr_t SramBase = 32'h8000_0000;

  // sizes in words
  localparam int unsigned RomWords  = 16;
  localparam int unsigned SramWords = 256;

  localparam int unsigned RomBytes     = RomWords * StrbWidth;
  localparam int unsigned SramBytes    = SramWords * StrbWidth;
  localparam int unsigned RomIdxWidth  = $clog2(RomWords);
  localparam int unsigned SramIdxWidth = $clog2(SramWords);

  // boot word i holds {i, i ^ RomTag}
  localparam logic [31:0] RomTag = 32'hB007_C0DE;

  // debug request held off this many cycles after power-on
  localparam int unsigned DebugDelayCycles = 64;
  localparam int unsigned DebugCntWidth    = $clog2(DebugDelayCycles + 1);

  typedef enum logic [1:0] {
    TgtRom  = 2'd0,
    TgtSram = 2'd1,
    TgtExit = 2'd2,
    TgtNone = 2'd3
  } target_e;

  // window lookup, anything outside the three windows is unmapped
  function automatic target_e decode_target(addr_t addr);
    target_e tgt;
    addr_t   rom_off;
    addr_t   sram_off;
    rom_off  = addr - RomBase;
    sram_off = addr - SramBase;
    if (rom_off < RomBytes) begin
      tgt = TgtRom;
    end else if (sram_off < SramBytes) begin
      tgt = TgtSram;
    end else if ((addr & WordMask) == ExitBase) begin
      tgt = TgtExit;
    end else begin
      tgt = TgtNone;
    end
    return tgt;
  endfunction

endpackage

//--- logic/sram_bank.sv
// word-addressed ram with byte-enable writes
// registered read

`timescale 1ns/1ps

module sram_bank (
  input  logic      clk_i,
  input  logic      rst_ni,
  mem_bus_if.slave  bus
);

  import bus_pkg::*;
  import soc_pkg::*;

  data_t                   mem_q [SramWords];
  logic [SramIdxWidth-1:0] idx;
  logic                    wr_en;

  assign idx = bus.addr[WordOffset +: SramIdxWidth];

  // nothing lands in the array while the platform is in reset
  assign wr_en = bus.req && bus.we && rst_ni;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      bus.rvalid <= 1'b0;
    end else begin
      bus.rvalid <= bus.req;
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      for (int b = 0; b < StrbWidth; b++) begin
        if (bus.be[b]) begin
          mem_q[idx][b*ByteWidth +: ByteWidth] <= bus.wdata[b*ByteWidth +: ByteWidth];
        end
      end
    end
    // write requests read back zero
    if (bus.req && !bus.we) begin
      bus.rdata <= mem_q[idx];
    end else begin
      bus.rdata <= '0;
    end
  end

  assign bus.err = 1'b0;

  // decode upstream keeps every request inside the array
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    bus.req |-> ((bus.addr >> WordOffset) < SramWords))
    else $error("sram request outside the array");

endmodule

//--- sources.f
+incdir+verif
logic/bus_pkg.sv
logic/soc_pkg.sv
logic/mem_bus_if.sv
logic/reset_sync.sv
logic/debug_req_gate.sv
logic/addr_demux.sv
logic/boot_rom.sv
logic/sram_bank.sv
logic/exit_reg.sv
logic/soc_harness_top.sv
verif/tb_soc_harness.sv

//--- verif/tb_ref_model.svh
// testbench reference model: boot table rule, address decode,
// xorshift, and shadow state for the sram and the exit register

`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// shadow copies, updated in request order
data_t       shadow_sram [SramWords];
logic [31:0] shadow_exit = '0;

// boot word i: index in the upper half, index xor tag in the lower half
function automatic data_t rom_word(input int unsigned idx);
  logic [31:0] hi;
  hi = idx;
  return {hi, hi ^ RomTag};
endfunction

// byte ranges of the three windows
function automatic target_e map_target(input addr_t addr);
  if (addr >= RomBase && addr < RomBase + RomBytes) begin
    return TgtRom;
  end
  if (addr >= SramBase && addr < SramBase + SramBytes) begin
    return TgtSram;
  end
  if (addr >= ExitBase && addr < ExitBase + StrbWidth) begin
    return TgtExit;
  end
  return TgtNone;
endfunction

function automatic logic [31:0] xorshift32(input logic [31:0] x);
  logic [31:0] s;
  s = x;
  s = s ^ (s << 13);
  s = s ^ (s >> 17);
  s = s ^ (s << 5);
  return s;
endfunction

// expected response of one request, shadow state follows writes
function automatic void predict(input logic we, input addr_t addr, input strb_t be,
                                input data_t wdata, output data_t data, output logic err);
  int unsigned idx;
  data = '0;
  err  = 1'b0;
  case (map_target(addr))
    TgtRom: begin
      idx = (addr - RomBase) >> WordOffset;
      if (we) begin
        err = 1'b1;
      end else begin
        data = rom_word(idx);
      end
    end
    TgtSram: begin
      idx = (addr - SramBase) >> WordOffset;
      if (we) begin
        for (int b = 0; b < StrbWidth; b++) begin
          if (be[b]) begin
            shadow_sram[idx][b*ByteWidth +: ByteWidth] = wdata[b*ByteWidth +: ByteWidth];
          end
        end
      end else begin
        data = shadow_sram[idx];
      end
    end
    TgtExit: begin
      if (we) begin
        shadow_exit = wdata[31:0];
      end else begin
        data = {32'h0, shadow_exit};
      end
    end
    default: begin
      err = 1'b1;
    end
  endcase
endfunction

`endif

//--- verif/tb_soc_harness.sv
// testbench for the platform top
// bus stimulus, response checker, debug gate and reset checks

`timescale 1ns/1ps

module tb_soc_harness;

  import bus_pkg::*;
  import soc_pkg::*;

  localparam int unsigned ClkPeriod    = 40;
  localparam int unsigned ResetCycles  = 16;
  localparam int unsigned DrainTimeout = 200;
  localparam int unsigned SramPicks    = 12;
  localparam logic [31:0] Seed         = 32'd63;

  logic        clk_i;
  logic        rst_ni;
  logic        ndmreset_i;
  logic        dbg_req_i;
  logic        dbg_enable_i;
  logic        req_i;
  logic        we_i;
  addr_t       addr_i;
  strb_t       be_i;
  data_t       wdata_i;
  logic        rvalid_o;
  logic        err_o;
  logic        debug_req_o;
  data_t       rdata_o;
  logic [31:0] exit_o;

  logic [31:0] rng_state = Seed;
  int unsigned neg_cnt   = 0;

  // outstanding responses in request order
  string       exp_name [$];
  data_t       exp_data [$];
  logic        exp_err  [$];
  int unsigned exp_due  [$];

  `include "tb_ref_model.svh"

  soc_harness_top soc_harness_top_i (
    .clk_i        ( clk_i        ),
    .rst_ni       ( rst_ni       ),
    .ndmreset_i   ( ndmreset_i   ),
    .dbg_req_i    ( dbg_req_i    ),
    .dbg_enable_i ( dbg_enable_i ),
    .req_i        ( req_i        ),
    .we_i         ( we_i         ),
    .addr_i       ( addr_i       ),
    .be_i         ( be_i         ),
    .wdata_i      ( wdata_i      ),
    .rvalid_o     ( rvalid_o     ),
    .err_o        ( err_o        ),
    .debug_req_o  ( debug_req_o  ),
    .rdata_o      ( rdata_o      ),
    .exit_o       ( exit_o       )
  );

  initial begin
    clk_i = 1'b0;
    forever #(ClkPeriod / 2) clk_i = ~clk_i;
  end

  // --------------------
  // helpers
  // --------------------

  function automatic logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  task automatic stop_with_error(input string what);
    $display("%s", what);
    $display("Errors found");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_data(input string name, input data_t exp, input data_t act);
    if (act !== exp) begin
      stop_with_error($sformatf("** Error %s: expected %h, actual %h", name, exp, act));
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      stop_with_error($sformatf("** Error %s: expected %b, actual %b", name, exp, act));
    end
  endtask

  task automatic check_exit(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      stop_with_error($sformatf("** Error %s: expected %h, actual %h", name, exp, act));
    end
  endtask

  // one request cycle
  // its response is due two falling edges later
  task automatic bus_request(input string name, input logic we, input addr_t addr,
                             input strb_t be, input data_t wdata, input bit expect_rsp);
    data_t data;
    logic  err;
    @(posedge clk_i);
    req_i   <= 1'b1;
    we_i    <= we;
    addr_i  <= addr;
    be_i    <= be;
    wdata_i <= wdata;
    if (expect_rsp) begin
      predict(we, addr, be, wdata, data, err);
      exp_name.push_back(name);
      exp_data.push_back(data);
      exp_err.push_back(err);
      exp_due.push_back(neg_cnt + 2);
    end
  endtask

  task automatic bus_idle();
    @(posedge clk_i);
    req_i <= 1'b0;
    we_i  <= 1'b0;
  endtask

  task automatic wait_drain(input string what);
    int unsigned n;
    n = 0;
    while (exp_name.size() != 0 && n < DrainTimeout) begin
      @(posedge clk_i);
      n++;
    end
    if (exp_name.size() != 0) begin
      stop_with_error($sformatf("timeout: %0d responses never arrived during %s",
                                exp_name.size(), what));
    end
  endtask

  // --------------------
  // response checker
  // --------------------

  initial begin : response_checker
    forever begin
      @(negedge clk_i);
      neg_cnt++;
      if (rvalid_o !== 1'b0) begin
        if (exp_name.size() == 0) begin
          stop_with_error("a response came out with no request outstanding");
        end else if (exp_due[0] != neg_cnt) begin
          stop_with_error($sformatf("response for %s came a cycle early", exp_name[0]));
        end else begin
          check_flag({exp_name[0], "_err"}, exp_err[0], err_o);
          check_data(exp_name[0], exp_data[0], rdata_o);
          void'(exp_name.pop_front());
          void'(exp_data.pop_front());
          void'(exp_err.pop_front());
          void'(exp_due.pop_front());
        end
      end else if (exp_name.size() != 0 && exp_due[0] <= neg_cnt) begin
        stop_with_error($sformatf("no response one cycle after the %s request", exp_name[0]));
      end
    end
  end

  // --------------------
  // test sequence
  // --------------------

  initial begin : main_sequence
    int unsigned sram_idx [SramPicks];
    logic [31:0] code;
    logic [31:0] rnd;
    addr_t       addr;
    int unsigned tries;

    rst_ni       = 1'b0;
    ndmreset_i   = 1'b0;
    dbg_req_i    = 1'b1;
    dbg_enable_i = 1'b1;
    req_i        = 1'b0;
    we_i         = 1'b0;
    addr_i       = '0;
    be_i         = '0;
    wdata_i      = '0;

    for (int i = 0; i < ResetCycles; i++) begin
      @(negedge clk_i);
      check_flag("debug_in_reset", 1'b0, debug_req_o);
    end
    @(posedge clk_i);
    rst_ni <= 1'b1;

    // debug hold-off over k rising edges since release
    for (int k = 0; k <= DebugDelayCycles; k++) begin
      @(negedge clk_i);
      check_flag("debug_holdoff", (k >= DebugDelayCycles), debug_req_o);
    end
    @(posedge clk_i);
    dbg_enable_i <= 1'b0;
    @(negedge clk_i);
    check_flag("debug_disabled", 1'b0, debug_req_o);
    check_exit("exit_after_reset", 32'h0, exit_o);

    // boot rom reads back to back
    for (int i = 0; i < RomWords; i++) begin
      bus_request("rom_read", 1'b0, RomBase + i * StrbWidth, '1, '0, 1'b1);
    end
    bus_request("rom_read_unaligned", 1'b0, RomBase + 8'h2b, '1, '0, 1'b1);
    bus_request("rom_write", 1'b1, RomBase + 8'h10, '1, data_t'(64'hdead), 1'b1);
    bus_idle();
    wait_drain("rom reads");

    // full sram words first so every byte is known
    for (int i = 0; i < SramPicks; i++) begin
      sram_idx[i] = next_rand() % SramWords;
      bus_request("sram_fill", 1'b1, SramBase + sram_idx[i] * StrbWidth, '1,
                  {next_rand(), next_rand()}, 1'b1);
    end
    for (int i = 0; i < 2 * SramPicks; i++) begin
      addr = SramBase + sram_idx[next_rand() % SramPicks] * StrbWidth;
      bus_request("sram_byte_write", 1'b1, addr, strb_t'(next_rand()),
                  {next_rand(), next_rand()}, 1'b1);
    end
    for (int i = 0; i < SramPicks; i++) begin
      bus_request("sram_read", 1'b0, SramBase + sram_idx[i] * StrbWidth, '1, '0, 1'b1);
    end
    bus_idle();
    wait_drain("sram byte enables");

    // upper half of the exit write data is dropped
    code = next_rand();
    bus_request("exit_write", 1'b1, ExitBase, '1, {next_rand(), code}, 1'b1);
    bus_request("exit_read", 1'b0, ExitBase, '1, '0, 1'b1);
    bus_idle();
    wait_drain("exit register");
    check_exit("exit_value", code, exit_o);

    // just outside each window
    bus_request("unmapped_edge", 1'b0, RomBase - StrbWidth, '1, '0, 1'b1);
    bus_request("unmapped_edge", 1'b1, RomBase + RomBytes, '1, '1, 1'b1);
    bus_request("unmapped_edge", 1'b0, SramBase - StrbWidth, '1, '0, 1'b1);
    bus_request("unmapped_edge", 1'b0, SramBase + SramBytes, '1, '0, 1'b1);
    bus_request("unmapped_edge", 1'b0, ExitBase - StrbWidth, '1, '0, 1'b1);
    bus_request("unmapped_edge", 1'b1, ExitBase + StrbWidth, '1, '1, 1'b1);
    for (int i = 0; i < 8; i++) begin
      tries = 0;
      addr  = next_rand();
      while (map_target(addr) != TgtNone && tries < 16) begin
        addr = next_rand();
        tries++;
      end
      if (map_target(addr) != TgtNone) begin
        stop_with_error("could not draw an unmapped address");
      end
      rnd = next_rand();
      bus_request("unmapped_random", rnd[0], addr, '1, {next_rand(), next_rand()}, 1'b1);
    end
    bus_idle();
    wait_drain("unmapped addresses");

    // sram writes during the non-debug reset are ignored and stay unanswered
    @(posedge clk_i);
    ndmreset_i <= 1'b1;
    for (int i = 0; i < 6; i++) begin
      bus_request("in_reset", 1'b1, SramBase + sram_idx[i] * StrbWidth, '1,
                  {next_rand(), next_rand()}, 1'b0);
      @(negedge clk_i);
      check_exit("exit_in_reset", 32'h0, exit_o);
    end
    @(posedge clk_i);
    ndmreset_i <= 1'b0;
    req_i      <= 1'b0;
    we_i       <= 1'b0;
    shadow_exit = '0;
    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    check_exit("exit_after_ndmreset", 32'h0, exit_o);
    for (int i = 0; i < SramPicks; i++) begin
      bus_request("sram_after_ndmreset", 1'b0, SramBase + sram_idx[i] * StrbWidth, '1, '0,
                  1'b1);
    end
    bus_request("exit_after_ndmreset_read", 1'b0, ExitBase, '1, '0, 1'b1);
    bus_idle();
    wait_drain("reads after the non-debug reset");

    $display("No errors");
    $finish;
  end

endmodule
